/* rv_core_settings.svh */
// Core width, register file size, reset pc and NOP encoding constants
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Integer register file
`define RV_NREGS  32
`define RV_REG_AW 5

// First fetch address
`define RV_RESET_PC 32'h0000_0000

// ADDI x0,x0,0 for squashed slots
`define RV_NOP_INST 32'h0000_0013

`endif

/* rv_core_pkg.sv */
// Opcode and ALU enums, pipeline register structs, data port request and forwarding match
`include "rv_core_settings.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   rs1_val;
        logic [`RV_XLEN-1:0]   rs2_val;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_REG_AW-1:0] rs1_addr;
        logic [`RV_REG_AW-1:0] rs2_addr;
        logic [`RV_REG_AW-1:0] rd;
        alu_op_e               alu_op;
        logic                  alu_src;    // Immediate as second operand
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
        logic                  is_load;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_XLEN-1:0]   store_data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_write;
        logic [`RV_XLEN-1:0]   value;
    } wb_t;

    typedef struct packed {
        logic                  wen;
        logic [`RV_XLEN-3:0]   addr;       // Word address
        logic [`RV_XLEN-1:0]   wdata;
    } dmem_req_t;

    // Producer rd matches a source and really writes it
    function automatic logic fwd_hit(
        input logic [`RV_REG_AW-1:0] src,
        input logic [`RV_REG_AW-1:0] rd,
        input logic                  we
    );
        return we && (rd != '0) && (rd == src);
    endfunction

endpackage

/* rv_fetch.sv */
// Fetch stage: pc register, next pc selection and IF/ID register with squash
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 hold,
    input  logic                 redirect,
    input  logic [`RV_XLEN-1:0]  redirect_pc,
    input  logic [`RV_XLEN-1:0]  imem_rdata,
    output logic [`RV_XLEN-3:0]  imem_addr,
    output logic [`RV_XLEN-1:0]  pc,
    output rv_core_pkg::if_id_t  if_id
);

    assign imem_addr = pc[`RV_XLEN-1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= `RV_RESET_PC;
            if_id.pc   <= `RV_RESET_PC;
            if_id.inst <= `RV_NOP_INST;
        end else if (!stall && !hold) begin
            if_id.pc <= pc;
            if (redirect) begin
                pc         <= redirect_pc;
                if_id.inst <= `RV_NOP_INST;   // Squash the wrong-path word
            end else begin
                pc         <= pc + `RV_XLEN'(4);
                if_id.inst <= imem_rdata;
            end
        end
    end

endmodule

/* rv_inst_decoder.sv */
// Instruction decoder: opcode sort, immediate build and ALU operation select
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_inst_decoder (
    input  logic [`RV_XLEN-1:0]  inst,
    output rv_core_pkg::alu_op_e op,
    output logic [`RV_XLEN-1:0]  imm,
    output logic                 alu_src,
    output logic                 reg_write,
    output logic                 mem_to_reg,
    output logic                 mem_write,
    output logic                 is_load,
    output logic                 is_branch,
    output logic                 is_bne,
    output logic                 is_jal
);

    logic [`RV_XLEN-1:0]  imm_i;
    logic [`RV_XLEN-1:0]  imm_s;
    logic [`RV_XLEN-1:0]  imm_b;
    logic [`RV_XLEN-1:0]  imm_j;
    logic [`RV_XLEN-1:0]  shamt;
    logic                 sub_sel;
    rv_core_pkg::alu_op_e f3_op;

    assign imm_i   = {{20{inst[31]}}, inst[31:20]};
    assign imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign shamt   = {27'd0, inst[24:20]};
    assign sub_sel = inst[30] && (inst[6:0] == rv_core_pkg::OPC_OP);  // No SUBI

    always_comb begin
        case (inst[14:12])
            3'b000:  f3_op = sub_sel ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  f3_op = rv_core_pkg::ALU_SLL;
            3'b010:  f3_op = rv_core_pkg::ALU_SLT;
            3'b100:  f3_op = rv_core_pkg::ALU_XOR;
            3'b101:  f3_op = inst[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  f3_op = rv_core_pkg::ALU_OR;
            default: f3_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        op         = rv_core_pkg::ALU_ADD;
        imm        = imm_i;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        is_load    = 1'b0;
        is_branch  = 1'b0;
        is_bne     = 1'b0;
        is_jal     = 1'b0;
        case (inst[6:0])
            rv_core_pkg::OPC_OP: begin
                op        = f3_op;
                reg_write = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                op        = f3_op;
                imm       = (inst[13:12] == 2'b01) ? shamt : imm_i;  // SLLI, SRLI, SRAI
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            rv_core_pkg::OPC_LOAD: begin
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                is_load    = 1'b1;
            end
            rv_core_pkg::OPC_STORE: begin
                imm       = imm_s;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm       = imm_b;
                is_branch = 1'b1;
                is_bne    = inst[12];
            end
            rv_core_pkg::OPC_JAL: begin
                imm       = imm_j;
                reg_write = 1'b1;       // Link value built in decode
                is_jal    = 1'b1;
            end
            default: ;                  // Unsupported opcodes act as NOP
        endcase
    end

endmodule

/* rv_regfile.sv */
// Integer register file with two asynchronous read ports and one write port
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  rv_core_pkg::wb_t      wb
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && (wb.rd != '0) && !stall) begin
            regs[wb.rd] <= wb.value;    // x0 stays zero
        end
    end

endmodule

/* rv_decode.sv */
// Decode stage: branch and JAL resolve, operand bypass, load-use hold and ID/EX register
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  rv_core_pkg::if_id_t   if_id,
    output logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    input  logic [`RV_XLEN-1:0]   ex_result,
    input  rv_core_pkg::ex_mem_t  ex_fwd,
    input  rv_core_pkg::wb_t      wb,
    output logic                  redirect,
    output logic [`RV_XLEN-1:0]   redirect_pc,
    output logic                  hold,
    output rv_core_pkg::id_ex_t   id_ex
);

    rv_core_pkg::alu_op_e op;
    rv_core_pkg::id_ex_t  id_ex_d;
    logic [`RV_XLEN-1:0]  imm;
    logic                 alu_src;
    logic                 reg_write;
    logic                 mem_to_reg;
    logic                 mem_write;
    logic                 is_load;
    logic                 is_branch;
    logic                 is_bne;
    logic                 is_jal;
    logic [`RV_XLEN-1:0]  cmp1;
    logic [`RV_XLEN-1:0]  cmp2;
    logic                 load_hazard;
    logic                 branch_hazard;
    logic                 taken;

    rv_inst_decoder u_dec (
        .inst       (if_id.inst),
        .op         (op),
        .imm        (imm),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .mem_to_reg (mem_to_reg),
        .mem_write  (mem_write),
        .is_load    (is_load),
        .is_branch  (is_branch),
        .is_bne     (is_bne),
        .is_jal     (is_jal)
    );

    assign rs1_addr = if_id.inst[19:15];
    assign rs2_addr = if_id.inst[24:20];

    // Compare operands: execute, then memory, then write-back, then file
    assign cmp1 = rv_core_pkg::fwd_hit(rs1_addr, id_ex.rd, id_ex.reg_write) ? ex_result :
                  rv_core_pkg::fwd_hit(rs1_addr, ex_fwd.rd, ex_fwd.reg_write) ? ex_fwd.result :
                  rv_core_pkg::fwd_hit(rs1_addr, wb.rd, wb.reg_write) ? wb.value : rs1_data;
    assign cmp2 = rv_core_pkg::fwd_hit(rs2_addr, id_ex.rd, id_ex.reg_write) ? ex_result :
                  rv_core_pkg::fwd_hit(rs2_addr, ex_fwd.rd, ex_fwd.reg_write) ? ex_fwd.result :
                  rv_core_pkg::fwd_hit(rs2_addr, wb.rd, wb.reg_write) ? wb.value : rs2_data;

    assign load_hazard   = !is_jal && (rv_core_pkg::fwd_hit(rs1_addr, id_ex.rd, id_ex.is_load) ||
                                       rv_core_pkg::fwd_hit(rs2_addr, id_ex.rd, id_ex.is_load));
    // A branch also waits while its load sits in memory, the data is not back yet
    assign branch_hazard = is_branch &&
                           (rv_core_pkg::fwd_hit(rs1_addr, ex_fwd.rd, ex_fwd.mem_to_reg) ||
                            rv_core_pkg::fwd_hit(rs2_addr, ex_fwd.rd, ex_fwd.mem_to_reg));
    assign hold          = load_hazard || branch_hazard;

    assign taken       = is_branch && (is_bne ? (cmp1 != cmp2) : (cmp1 == cmp2));
    assign redirect    = (taken || is_jal) && !hold;
    assign redirect_pc = if_id.pc + imm;

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.rs1_val    = rv_core_pkg::fwd_hit(rs1_addr, wb.rd, wb.reg_write) ? wb.value
                                                                                  : rs1_data;
        id_ex_d.rs2_val    = rv_core_pkg::fwd_hit(rs2_addr, wb.rd, wb.reg_write) ? wb.value
                                                                                  : rs2_data;
        id_ex_d.rs1_addr   = rs1_addr;
        id_ex_d.rs2_addr   = rs2_addr;
        id_ex_d.imm        = imm;
        id_ex_d.rd         = if_id.inst[11:7];
        id_ex_d.alu_op     = op;
        id_ex_d.alu_src    = alu_src;
        id_ex_d.reg_write  = reg_write;
        id_ex_d.mem_to_reg = mem_to_reg;
        id_ex_d.mem_write  = mem_write;
        id_ex_d.is_load    = is_load;
        if (is_jal) begin
            id_ex_d.rs1_val  = if_id.pc;         // Link is pc + 4 through the ALU
            id_ex_d.rs2_val  = `RV_XLEN'(4);
            id_ex_d.rs1_addr = '0;
            id_ex_d.rs2_addr = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= hold ? '0 : id_ex_d;       // Bubble during hold
        end
    end

endmodule

/* rv_execute.sv */
// Execute stage: forwarding, operand select, ALU and EX/MEM register
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  rv_core_pkg::id_ex_t  id_ex,
    input  rv_core_pkg::ex_mem_t mem_fwd,
    input  rv_core_pkg::wb_t     wb,
    output logic [`RV_XLEN-1:0]  result,
    output rv_core_pkg::ex_mem_t ex_mem
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_fwd;
    logic [`RV_XLEN-1:0] op_b;

    // Memory stage wins over write-back
    assign op_a = rv_core_pkg::fwd_hit(id_ex.rs1_addr, mem_fwd.rd, mem_fwd.reg_write) ?
                      mem_fwd.result :
                  rv_core_pkg::fwd_hit(id_ex.rs1_addr, wb.rd, wb.reg_write) ?
                      wb.value : id_ex.rs1_val;
    assign rs2_fwd = rv_core_pkg::fwd_hit(id_ex.rs2_addr, mem_fwd.rd, mem_fwd.reg_write) ?
                         mem_fwd.result :
                     rv_core_pkg::fwd_hit(id_ex.rs2_addr, wb.rd, wb.reg_write) ?
                         wb.value : id_ex.rs2_val;
    assign op_b = id_ex.alu_src ? id_ex.imm : rs2_fwd;

    always_comb begin
        case (id_ex.alu_op)
            rv_core_pkg::ALU_SUB: result = op_a - op_b;
            rv_core_pkg::ALU_SLT: result = `RV_XLEN'($signed(op_a) < $signed(op_b));
            rv_core_pkg::ALU_AND: result = op_a & op_b;
            rv_core_pkg::ALU_OR:  result = op_a | op_b;
            rv_core_pkg::ALU_XOR: result = op_a ^ op_b;
            rv_core_pkg::ALU_SLL: result = op_a << op_b[4:0];
            rv_core_pkg::ALU_SRL: result = op_a >> op_b[4:0];
            rv_core_pkg::ALU_SRA: result = $signed(op_a) >>> op_b[4:0];
            default:              result = op_a + op_b;  // ADD, address, link
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem.result     <= result;
            ex_mem.store_data <= rs2_fwd;       // Forwarded SW data
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.mem_write  <= id_ex.mem_write;
        end
    end

endmodule

/* rv_memory.sv */
// Memory stage: data port request, MEM/WB register and write-back value
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_memory (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  rv_core_pkg::ex_mem_t   ex_mem,
    input  logic [`RV_XLEN-1:0]    dmem_rdata,
    output rv_core_pkg::dmem_req_t dmem_req,
    output rv_core_pkg::wb_t       wb
);

    logic [`RV_XLEN-1:0]   load_q;
    logic [`RV_XLEN-1:0]   alu_q;
    logic [`RV_REG_AW-1:0] rd_q;
    logic                  reg_write_q;
    logic                  mem_to_reg_q;

    assign dmem_req.wen   = ex_mem.mem_write;
    assign dmem_req.addr  = ex_mem.result[`RV_XLEN-1:2];
    assign dmem_req.wdata = ex_mem.store_data;

    // Control bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end else if (!stall) begin
            reg_write_q  <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            load_q <= dmem_rdata;               // Same-cycle read data
            alu_q  <= ex_mem.result;
            rd_q   <= ex_mem.rd;
        end
    end

    assign wb.rd        = rd_q;
    assign wb.reg_write = reg_write_q;
    assign wb.value     = mem_to_reg_q ? load_q : alu_q;

endmodule

/* rv_core.sv */
// Top level of the five-stage pipeline with global stall and stage wiring
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [`RV_XLEN-3:0]    imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_rdata,
    input  logic                   imem_stall,
    output rv_core_pkg::dmem_req_t dmem_req,
    input  logic [`RV_XLEN-1:0]    dmem_rdata,
    input  logic                   dmem_stall,
    output logic [`RV_XLEN-1:0]    pc
);

    logic                  stall;
    logic                  hold;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   redirect_pc;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   ex_result;
    rv_core_pkg::if_id_t   if_id;
    rv_core_pkg::id_ex_t   id_ex;
    rv_core_pkg::ex_mem_t  ex_mem;
    rv_core_pkg::wb_t      wb;

    assign stall = imem_stall | dmem_stall;   // Freezes every stage

    rv_fetch u_fetch (
        .clk, .rst_n, .stall, .hold, .redirect, .redirect_pc,
        .imem_rdata, .imem_addr, .pc, .if_id
    );

    rv_decode u_decode (
        .clk, .rst_n, .stall, .if_id,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_result,
        .ex_fwd     (ex_mem),
        .wb, .redirect, .redirect_pc, .hold, .id_ex
    );

    rv_regfile u_regfile (
        .clk, .rst_n, .stall,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .wb
    );

    rv_execute u_execute (
        .clk, .rst_n, .stall, .id_ex,
        .mem_fwd    (ex_mem),
        .wb,
        .result     (ex_result),
        .ex_mem
    );

    rv_memory u_memory (
        .clk, .rst_n, .stall, .ex_mem, .dmem_rdata, .dmem_req, .wb
    );

endmodule

/* rv_core_props.sv */
// Concurrent assertions on the core top level and their bind to rv_core
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   stall,
    input logic                   redirect,
    input logic [`RV_XLEN-1:0]    redirect_pc,
    input logic [`RV_XLEN-1:0]    pc,
    input rv_core_pkg::dmem_req_t dmem_req
);

    wen_in_reset: assert property (@(posedge clk) !rst_n |=> !dmem_req.wen)
        else $error("store request raised while reset is applied");

    // Whole pipeline frozen, so the request and the pc must not move
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(pc) && $stable(dmem_req))
        else $error("pc or data request moved during a stall");

    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(pc) |-> (pc == $past(pc) + `RV_XLEN'(4)) ||
                         ($past(redirect) && (pc == $past(redirect_pc))))
        else $error("pc changed by something other than four or a redirect");

endmodule

bind rv_core rv_core_props u_props (
    .clk, .rst_n, .stall, .redirect, .redirect_pc, .pc, .dmem_req
);

/* tb_rv_core.sv */
// Testbench for rv_core: program image, memory models, reference model, checks and verdict
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module tb_rv_core;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;

    logic                   clk;
    logic                   rst_n;
    logic                   imem_stall;
    logic                   dmem_stall;
    logic [`RV_XLEN-3:0]    imem_addr;
    logic [`RV_XLEN-1:0]    imem_rdata;
    logic [`RV_XLEN-1:0]    dmem_rdata;
    logic [`RV_XLEN-1:0]    pc;
    rv_core_pkg::dmem_req_t dmem_req;

    logic [31:0]            prog [IMEM_WORDS];
    logic [31:0]            dmem [DMEM_WORDS];
    logic [31:0]            dmem_init [DMEM_WORDS];
    rv_core_pkg::dmem_req_t exp_stores [$];
    logic [31:0]            loop_pc;
    logic                   stalls_on;
    int                     n_words;
    int                     n_inst;
    int                     n_expected;
    int                     n_captured = 0;
    int                     val_errs = 0;
    int                     other_errs = 0;
    int                     cycles = 0;
    int                     limit = 0;

    rv_core DUT (
        .clk, .rst_n, .imem_addr, .imem_rdata, .imem_stall,
        .dmem_req, .dmem_rdata, .dmem_stall, .pc
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    assign imem_rdata = prog[imem_addr[5:0]];
    assign dmem_rdata = dmem[dmem_req.addr[5:0]];   // Combinational read

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input rv_core_pkg::opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[n_words] = word;
        n_words++;
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = `RV_NOP_INST;
        end
        n_words = 0;
        emit(i_type(12'd128, 5'd0, 3'b000, 5'd1, rv_core_pkg::OPC_OP_IMM));  // Store base
        emit(i_type(12'd0, 5'd0, 3'b010, 5'd2, rv_core_pkg::OPC_LOAD));
        emit(i_type(12'd4, 5'd0, 3'b010, 5'd3, rv_core_pkg::OPC_LOAD));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));                       // Load-use on x3
        emit(s_type(12'd0, 5'd4, 5'd1));
        emit(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5));
        emit(s_type(12'd4, 5'd5, 5'd1));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd6));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd7));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd8));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd9));
        emit(s_type(12'd8, 5'd6, 5'd1));
        emit(s_type(12'd12, 5'd7, 5'd1));
        emit(s_type(12'd16, 5'd8, 5'd1));
        emit(s_type(12'd20, 5'd9, 5'd1));
        emit(i_type(12'hffb, 5'd2, 3'b000, 5'd10, rv_core_pkg::OPC_OP_IMM)); // ADDI -5
        emit(i_type(12'h0f0, 5'd2, 3'b111, 5'd11, rv_core_pkg::OPC_OP_IMM));
        emit(i_type(12'h8f0, 5'd3, 3'b110, 5'd12, rv_core_pkg::OPC_OP_IMM));
        emit(i_type(12'hfff, 5'd2, 3'b100, 5'd13, rv_core_pkg::OPC_OP_IMM));
        emit(i_type(12'd100, 5'd3, 3'b010, 5'd14, rv_core_pkg::OPC_OP_IMM));
        emit(i_type({7'h00, 5'd7}, 5'd2, 3'b001, 5'd15, rv_core_pkg::OPC_OP_IMM));
        emit(i_type({7'h00, 5'd9}, 5'd2, 3'b101, 5'd16, rv_core_pkg::OPC_OP_IMM));
        emit(i_type({7'h20, 5'd13}, 5'd3, 3'b101, 5'd17, rv_core_pkg::OPC_OP_IMM));
        for (int r = 10; r < 18; r++) begin
            emit(s_type(12'(24 + 4 * (r - 10)), 5'(r), 5'd1));
        end
        emit(i_type(12'd3, 5'd10, 3'b000, 5'd18, rv_core_pkg::OPC_OP_IMM));
        emit(r_type(7'h00, 5'd11, 5'd18, 3'b000, 5'd19));                    // Distance one
        emit(r_type(7'h00, 5'd19, 5'd18, 3'b100, 5'd20));                    // Distance two
        emit(r_type(7'h20, 5'd20, 5'd18, 3'b000, 5'd21));                    // Distance three
        emit(s_type(12'd56, 5'd21, 5'd1));
        emit(i_type(12'd8, 5'd0, 3'b010, 5'd22, rv_core_pkg::OPC_LOAD));
        emit(s_type(12'd60, 5'd22, 5'd1));
        emit(i_type(12'd12, 5'd0, 3'b010, 5'd23, rv_core_pkg::OPC_LOAD));
        emit(r_type(7'h00, 5'd22, 5'd23, 3'b000, 5'd24));
        emit(s_type(12'd64, 5'd24, 5'd1));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd25, rv_core_pkg::OPC_OP_IMM));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd26, rv_core_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd26, 5'd25, 3'b000));                           // BEQ taken
        emit(s_type(12'd68, 5'd2, 5'd1));
        emit(b_type(13'd8, 5'd26, 5'd25, 3'b001));                           // BNE not taken
        emit(s_type(12'd72, 5'd3, 5'd1));
        emit(i_type(12'd1, 5'd25, 3'b000, 5'd27, rv_core_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd25, 5'd27, 3'b000));                           // BEQ not taken
        emit(s_type(12'd76, 5'd27, 5'd1));
        emit(i_type(12'd0, 5'd27, 3'b000, 5'd29, rv_core_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd25, 5'd29, 3'b001));                           // BNE taken
        emit(s_type(12'd80, 5'd0, 5'd1));
        emit(j_type(21'd8, 5'd28));
        emit(s_type(12'd84, 5'd0, 5'd1));
        emit(s_type(12'd88, 5'd28, 5'd1));                                   // Link value
        emit(j_type(21'd0, 5'd0));                                           // Final loop
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];   // Arithmetic
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction-level run of the image, fills exp_stores, returns the instruction count
    function automatic int run_reference();
        logic [31:0]            regs [32];
        logic [31:0]            mem [DMEM_WORDS];
        logic [31:0]            rpc;
        logic [31:0]            next_pc;
        logic [31:0]            inst;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            imm;
        logic [31:0]            addr;
        rv_core_pkg::dmem_req_t st;
        int                     count;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = dmem_init[i];
        end
        rpc   = `RV_RESET_PC;
        count = 0;
        while (count < 10000) begin
            inst = prog[rpc[7:2]];
            count++;
            if (inst == j_type(21'd0, 5'd0)) begin
                break;
            end
            a       = regs[inst[19:15]];
            b       = regs[inst[24:20]];
            imm     = {{20{inst[31]}}, inst[31:20]};
            next_pc = rpc + 32'd4;
            case (inst[6:0])
                rv_core_pkg::OPC_OP:     regs[inst[11:7]] = alu_model(inst[14:12], inst[30], a, b);
                rv_core_pkg::OPC_OP_IMM: regs[inst[11:7]] =
                    alu_model(inst[14:12], inst[30] && (inst[14:12] == 3'b101), a, imm);
                rv_core_pkg::OPC_LOAD: begin
                    addr = a + imm;
                    regs[inst[11:7]] = mem[addr[7:2]];
                end
                rv_core_pkg::OPC_STORE: begin
                    addr     = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    st.wen   = 1'b1;
                    st.addr  = addr[31:2];
                    st.wdata = b;
                    exp_stores.push_back(st);
                    mem[addr[7:2]] = b;
                end
                rv_core_pkg::OPC_BRANCH: begin
                    if ((inst[12] && (a != b)) || (!inst[12] && (a == b))) begin
                        next_pc = rpc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                         inst[11:8], 1'b0};
                    end
                end
                rv_core_pkg::OPC_JAL: begin
                    regs[inst[11:7]] = rpc + 32'd4;
                    next_pc = rpc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                     inst[30:21], 1'b0};
                end
                default: ;
            endcase
            regs[0] = '0;
            rpc     = next_pc;
        end
        loop_pc = rpc;
        return count;
    endfunction

    task automatic check_store(input rv_core_pkg::dmem_req_t got,
                               input rv_core_pkg::dmem_req_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERR t=%0t dmem_req got wen=%0b addr=%08h wdata=%08h", $time,
                     got.wen, got.addr, got.wdata);
            $display("    exp wen=%0b addr=%08h wdata=%08h", exp.wen, exp.addr, exp.wdata);
        end
    endtask

    task automatic check_pc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERR t=%0t pc got=%08h exp=%08h", $time, got, exp);
        end
    endtask

    always @(posedge clk) begin
        imem_stall <= stalls_on && ($urandom_range(99) < 20);   // About one cycle in five
        dmem_stall <= stalls_on && ($urandom_range(99) < 20);
    end

    // Store accepted at the coming edge
    always @(negedge clk) begin
        if (rst_n && dmem_req.wen && !imem_stall && !dmem_stall) begin
            dmem[dmem_req.addr[5:0]] <= dmem_req.wdata;
        end
    end

    always @(negedge clk) begin
        if (rst_n && dmem_req.wen && !imem_stall && !dmem_stall) begin
            n_captured++;
            if (exp_stores.size() == 0) begin
                other_errs++;
                $display("Store at time %0t to word %08h was not expected", $time, dmem_req.addr);
            end else begin
                check_store(dmem_req, exp_stores.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((limit > 0) && (cycles >= limit)) begin
            $display("Run timed out after %0d cycles, %0d of %0d stores seen", cycles,
                     n_captured, n_expected);
            $display("Errors: value %0d, other %0d", val_errs, other_errs + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [`RV_XLEN-1:0] lo;
        logic [`RV_XLEN-1:0] hi;
        rst_n      = 1'b0;
        imem_stall = 1'b0;
        dmem_stall = 1'b0;
        stalls_on  = 1'b0;
        void'($urandom(96));
        load_program();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_init[i] = $urandom;
            dmem[i]      = dmem_init[i];
        end
        n_inst     = run_reference();
        n_expected = exp_stores.size();
        limit      = n_inst * 30 + 200;
        repeat (10) @(posedge clk);
        rst_n     <= 1'b1;
        stalls_on <= 1'b1;
        while (n_captured < n_expected) begin
            @(posedge clk);
        end
        stalls_on <= 1'b0;
        repeat (4) @(posedge clk);
        lo = '1;
        hi = '0;
        repeat (40) begin                 // pc should only toggle between loop and loop+4
            @(negedge clk);
            if (pc < lo) begin
                lo = pc;
            end
            if (pc > hi) begin
                hi = pc;
            end
        end
        check_pc(lo, loop_pc);
        check_pc(hi, loop_pc + `RV_XLEN'(4));
        $display("Errors: value %0d, other %0d", val_errs, other_errs);
        if ((val_errs + other_errs) == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_inst_decoder.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv
